/* all.f */
ccc_pkg.sv
ccc_decode.sv
ccc_seq.sv
ccc_get_data.sv
ccc_set_actions.sv
ccc_top.sv
tb_ccc.sv

/* ccc_decode.sv */
// CCC decoder that maps the captured command code to an operation record
`timescale 1ns/1ps
`default_nettype none

module ccc_decode
  import ccc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  ccc_code_t ccc_i,
  input  logic      ccc_valid_i,
  output ccc_cmd_t  cmd_o
);

  ccc_cmd_t cmd_d;

  // Classify the code as handed over by the primary FSM
  always_comb begin
    cmd_d.op        = OpNone;
    cmd_d.is_direct = ccc_i[BYTE_W-1];
    cmd_d.get_len   = '0;
    case (ccc_i)
      CCC_BCAST_RSTDAA:     cmd_d.op = OpRstdaa;
      CCC_BCAST_SETAASA:    cmd_d.op = OpSetaasa;
      CCC_DIRECT_ENEC:      cmd_d.op = OpEnec;
      CCC_DIRECT_DISEC:     cmd_d.op = OpDisec;
      CCC_DIRECT_SETDASA:   cmd_d.op = OpSetdasa;
      CCC_DIRECT_GETBCR: begin
        cmd_d.op      = OpGetBcr;
        cmd_d.get_len = CNT_W'(1);
      end
      CCC_DIRECT_GETDCR: begin
        cmd_d.op      = OpGetDcr;
        cmd_d.get_len = CNT_W'(1);
      end
      // Format 1 only
      CCC_DIRECT_GETSTATUS: begin
        cmd_d.op      = OpGetStatus;
        cmd_d.get_len = CNT_W'(2);
      end
      CCC_DIRECT_GETMWL: begin
        cmd_d.op      = OpGetMwl;
        cmd_d.get_len = CNT_W'(2);
      end
      // Third byte is the max IBI payload size
      CCC_DIRECT_GETMRL: begin
        cmd_d.op      = OpGetMrl;
        cmd_d.get_len = CNT_W'(3);
      end
      CCC_DIRECT_GETPID: begin
        cmd_d.op      = OpGetPid;
        cmd_d.get_len = CNT_W'(GET_MAX_BYTES);
      end
      default: begin
      end
    endcase
  end

  // Record held for the whole CCC
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_o <= '{op: OpNone, is_direct: 1'b0, get_len: '0};
    end else if (ccc_valid_i) begin
      cmd_o <= cmd_d;
    end
  end

endmodule

`default_nettype wire

/* ccc_get_data.sv */
// GET byte counter and selection of the outgoing CSR byte
`timescale 1ns/1ps
`default_nettype none

module ccc_get_data
  import ccc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  ccc_cmd_t          cmd_i,
  input  csr_get_t          csr_i,
  input  logic              get_load_i,
  input  logic              get_next_i,
  output logic [BYTE_W-1:0] get_byte_o,
  output logic              get_last_o
);

  logic [CNT_W-1:0]   cnt_q;
  logic [CNT_W-1:0]   byte_idx;
  logic [REPLY_W-1:0] reply;
  logic [REPLY_W-1:0] reply_shift;

  // Remaining bytes, current one included
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (get_load_i) begin
      cnt_q <= cmd_i.get_len;
    end else if (get_next_i && (cnt_q != '0)) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // Reply right aligned, first byte sits at the top of get_len bytes
  always_comb begin
    reply = '0;
    case (cmd_i.op)
      OpGetBcr:    reply[BYTE_W-1:0] = csr_i.bcr;
      OpGetDcr:    reply[BYTE_W-1:0] = csr_i.dcr;
      OpGetStatus: reply[15:0]       = csr_i.status;
      OpGetMwl:    reply[15:0]       = csr_i.mwl;
      // Max IBI payload fixed at 8'hFF
      OpGetMrl:    reply[23:0]       = {csr_i.mrl, 8'hFF};
      OpGetPid:    reply             = csr_i.pid;
      default: begin
      end
    endcase
  end

  // MSB first as the counter runs down
  assign byte_idx    = cnt_q - 1'b1;
  assign reply_shift = reply >> (BYTE_W * byte_idx);
  assign get_byte_o  = (cnt_q != '0) ? reply_shift[BYTE_W-1:0] : '0;
  assign get_last_o  = (cnt_q == CNT_W'(1));

endmodule

`default_nettype wire

/* ccc_pkg.sv */
// CCC handler package with widths, command codes, enums and record structs
`default_nettype none

package ccc_pkg;

  // Protocol widths
  localparam int unsigned ADDR_W        = 7;
  localparam int unsigned BYTE_W        = 8;
  localparam int unsigned GET_MAX_BYTES = 6;
  localparam int unsigned CNT_W         = $clog2(GET_MAX_BYTES + 1);
  localparam int unsigned REPLY_W       = GET_MAX_BYTES * BYTE_W;

  typedef logic [BYTE_W-1:0] ccc_code_t;

  // Broadcast address, also ends a direct CCC when sent with write
  localparam logic [ADDR_W-1:0] RSVD_ADDR = 7'h7E;

  // Broadcast codes
  localparam ccc_code_t CCC_BCAST_RSTDAA  = 8'h06;
  localparam ccc_code_t CCC_BCAST_SETAASA = 8'h29;

  // Direct codes
  localparam ccc_code_t CCC_DIRECT_ENEC      = 8'h80;
  localparam ccc_code_t CCC_DIRECT_DISEC     = 8'h81;
  localparam ccc_code_t CCC_DIRECT_SETDASA   = 8'h87;
  localparam ccc_code_t CCC_DIRECT_GETMWL    = 8'h8B;
  localparam ccc_code_t CCC_DIRECT_GETMRL    = 8'h8C;
  localparam ccc_code_t CCC_DIRECT_GETPID    = 8'h8D;
  localparam ccc_code_t CCC_DIRECT_GETBCR    = 8'h8E;
  localparam ccc_code_t CCC_DIRECT_GETDCR    = 8'h8F;
  localparam ccc_code_t CCC_DIRECT_GETSTATUS = 8'h90;

  typedef enum logic [3:0] {
    OpNone, OpRstdaa, OpSetaasa, OpEnec, OpDisec, OpSetdasa,
    OpGetBcr, OpGetDcr, OpGetStatus, OpGetMwl, OpGetMrl, OpGetPid
  } ccc_op_e;

  typedef struct packed {
    ccc_op_e          op;
    logic             is_direct;
    logic [CNT_W-1:0] get_len;
  } ccc_cmd_t;

  typedef enum logic [3:0] {
    Idle, RxTbit, RxDefByte, RxDefTbit, RxAddr, TxAddrAck,
    RxData, RxDataTbit, TxData, TxDataTbit, Bcast, Done
  } seq_state_e;

  // Requests toward the bit-level bus engine
  typedef struct packed {
    logic              rx_bit;
    logic              rx_byte;
    logic              tx_bit;
    logic              tx_byte;
    logic [BYTE_W-1:0] tx_value;
  } bus_req_t;

  // Bus monitor events and engine handshake
  typedef struct packed {
    logic              start_det;
    logic              rstart_det;
    logic              stop_det;
    logic              rx_done;
    logic              tx_done;
    logic [BYTE_W-1:0] rx_data;
  } bus_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] sta;
    logic              sta_valid;
    logic [ADDR_W-1:0] dyn;
    logic              dyn_valid;
  } target_addr_t;

  // CSR values read out by the GET CCCs
  typedef struct packed {
    logic [BYTE_W-1:0] bcr;
    logic [BYTE_W-1:0] dcr;
    logic [15:0]       status;
    logic [15:0]       mwl;
    logic [15:0]       mrl;
    logic [47:0]       pid;
  } csr_get_t;

  // One-cycle results of the SET and broadcast CCCs
  typedef struct packed {
    logic              enec_ibi;
    logic              enec_crr;
    logic              enec_hj;
    logic              disec_ibi;
    logic              disec_crr;
    logic              disec_hj;
    logic              rstdaa;
    logic              dasa_valid;
    logic [BYTE_W-1:0] dasa;
  } ccc_events_t;

endpackage

`default_nettype wire

/* ccc_seq.sv */
// CCC sequencer FSM with bus engine requests and direct address matching
`timescale 1ns/1ps
`default_nettype none

module ccc_seq
  import ccc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              ccc_valid_i,
  input  ccc_cmd_t          cmd_i,
  input  target_addr_t      addr_i,
  input  bus_rsp_t          bus_rsp_i,
  input  logic [BYTE_W-1:0] get_byte_i,
  input  logic              get_last_i,
  output bus_req_t          bus_req_o,
  output logic              get_load_o,
  output logic              get_next_o,
  output logic              data_stb_o,
  output logic [BYTE_W-1:0] data_byte_o,
  output logic              bcast_stb_o,
  output logic              done_o
);

  seq_state_e state_q, state_d;

  logic [ADDR_W-1:0] addr_q;
  logic              rnw_q;
  logic [BYTE_W-1:0] data_q;
  logic              last_q;
  logic              addr_match;
  logic              addr_rsvd;
  logic              in_ccc;

  // Dynamic address wins, static only while no dynamic one is assigned
  always_comb begin
    if (addr_i.dyn_valid) begin
      addr_match = (addr_q == addr_i.dyn);
    end else if (addr_i.sta_valid) begin
      addr_match = (addr_q == addr_i.sta);
    end else begin
      addr_match = 1'b0;
    end
  end

  // 7'h7E with write closes the direct CCC
  assign addr_rsvd = (addr_q == RSVD_ADDR) && !rnw_q;

  assign in_ccc = (state_q != Idle) && (state_q != Done);

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:       if (ccc_valid_i) state_d = RxTbit;
      // T-bit of the command code
      RxTbit: begin
        if (bus_rsp_i.rx_done) state_d = cmd_i.is_direct ? RxDefByte : Bcast;
      end
      // Defining bytes are skipped until the Repeated START
      RxDefByte: begin
        if (bus_rsp_i.rstart_det) state_d = RxAddr;
        else if (bus_rsp_i.rx_done) state_d = RxDefTbit;
      end
      RxDefTbit:  if (bus_rsp_i.rx_done) state_d = RxDefByte;
      RxAddr:     if (bus_rsp_i.rx_done) state_d = TxAddrAck;
      TxAddrAck: begin
        if (bus_rsp_i.tx_done) begin
          if (addr_rsvd) state_d = Done;
          else if (addr_match && rnw_q && (cmd_i.get_len != '0)) state_d = TxData;
          else if (addr_match && !rnw_q) state_d = RxData;
          // Other target or no reply, wait for the next address
          else state_d = RxDefByte;
        end
      end
      RxData: begin
        if (bus_rsp_i.start_det || bus_rsp_i.rstart_det) state_d = RxAddr;
        else if (bus_rsp_i.rx_done) state_d = RxDataTbit;
      end
      RxDataTbit: if (bus_rsp_i.rx_done) state_d = RxData;
      TxData: begin
        if (bus_rsp_i.start_det || bus_rsp_i.rstart_det) state_d = RxAddr;
        else if (bus_rsp_i.tx_done) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (bus_rsp_i.tx_done) state_d = last_q ? RxAddr : TxData;
      end
      Bcast:      state_d = Done;
      Done:       state_d = Idle;
      default:    state_d = Idle;
    endcase
  end

  // STOP ends any CCC in progress
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_rsp_i.stop_det && in_ccc) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

  // Address, direction, data byte and last flag
  always_ff @(posedge clk_i) begin
    if (state_q == RxAddr && bus_rsp_i.rx_done) begin
      addr_q <= bus_rsp_i.rx_data[BYTE_W-1:1];
      rnw_q  <= bus_rsp_i.rx_data[0];
    end
    if (state_q == RxData && bus_rsp_i.rx_done) begin
      data_q <= bus_rsp_i.rx_data;
    end
    // Counter moves on after the byte, so keep its last flag for the T-bit
    if (state_q == TxData && bus_rsp_i.tx_done) begin
      last_q <= get_last_i;
    end
  end

  always_comb begin
    bus_req_o   = '0;
    bcast_stb_o = 1'b0;
    done_o      = 1'b0;
    case (state_q)
      RxTbit, RxDefTbit, RxDataTbit: bus_req_o.rx_bit = 1'b1;
      // Drop the byte request once the Repeated START shows up
      RxDefByte:      bus_req_o.rx_byte = !bus_rsp_i.rstart_det;
      RxAddr, RxData: bus_req_o.rx_byte = 1'b1;
      // ACK driven low
      TxAddrAck:      bus_req_o.tx_bit = 1'b1;
      TxData: begin
        bus_req_o.tx_byte  = 1'b1;
        bus_req_o.tx_value = get_byte_i;
      end
      // T-bit high while more bytes follow
      TxDataTbit: begin
        bus_req_o.tx_bit   = 1'b1;
        bus_req_o.tx_value = {{(BYTE_W-1){1'b0}}, !last_q};
      end
      Bcast:          bcast_stb_o = 1'b1;
      Done:           done_o = 1'b1;
      default: begin
      end
    endcase
  end

  // Strobes toward the GET and SET blocks
  assign get_load_o  = (state_q == TxAddrAck) && bus_rsp_i.tx_done;
  assign get_next_o  = (state_q == TxData) && bus_rsp_i.tx_done;
  assign data_stb_o  = (state_q == RxDataTbit) && bus_rsp_i.rx_done;
  assign data_byte_o = data_q;

endmodule

`default_nettype wire

/* ccc_set_actions.sv */
// Registered one-cycle event pulses for the SET and broadcast CCCs
`timescale 1ns/1ps
`default_nettype none

module ccc_set_actions
  import ccc_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  ccc_cmd_t          cmd_i,
  input  logic [ADDR_W-1:0] sta_addr_i,
  input  logic              data_stb_i,
  input  logic [BYTE_W-1:0] data_byte_i,
  input  logic              bcast_stb_i,
  output ccc_events_t       events_o
);

  ccc_events_t events_d;

  // All fields fall back to zero, so each event lasts one cycle
  always_comb begin
    events_d = '0;
    if (data_stb_i) begin
      case (cmd_i.op)
        // Event bits: 0 IBI, 1 CRR, 3 HJ
        OpEnec: begin
          events_d.enec_ibi = data_byte_i[0];
          events_d.enec_crr = data_byte_i[1];
          events_d.enec_hj  = data_byte_i[3];
        end
        OpDisec: begin
          events_d.disec_ibi = data_byte_i[0];
          events_d.disec_crr = data_byte_i[1];
          events_d.disec_hj  = data_byte_i[3];
        end
        OpSetdasa: begin
          events_d.dasa_valid = 1'b1;
          events_d.dasa       = data_byte_i;
        end
        default: begin
        end
      endcase
    end
    if (bcast_stb_i) begin
      case (cmd_i.op)
        OpRstdaa: events_d.rstdaa = 1'b1;
        // Static address shares the SETDASA output
        OpSetaasa: begin
          events_d.dasa_valid = 1'b1;
          events_d.dasa       = {1'b0, sta_addr_i};
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      events_o <= '0;
    end else begin
      events_o <= events_d;
    end
  end

endmodule

`default_nettype wire

/* ccc_top.sv */
// CCC handler top level wiring decode, sequencer, GET data and SET actions
`timescale 1ns/1ps
`default_nettype none

module ccc_top
  import ccc_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  ccc_code_t    ccc_i,
  input  logic         ccc_valid_i,
  output logic         done_o,
  input  bus_rsp_t     bus_rsp_i,
  output bus_req_t     bus_req_o,
  input  target_addr_t addr_i,
  input  csr_get_t     csr_i,
  output ccc_events_t  events_o
);

  ccc_cmd_t          cmd;
  logic              get_load;
  logic              get_next;
  logic [BYTE_W-1:0] get_byte;
  logic              get_last;
  logic              data_stb;
  logic [BYTE_W-1:0] data_byte;
  logic              bcast_stb;

  ccc_decode u_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_i       (ccc_i),
    .ccc_valid_i (ccc_valid_i),
    .cmd_o       (cmd)
  );

  ccc_seq u_seq (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_valid_i (ccc_valid_i),
    .cmd_i       (cmd),
    .addr_i      (addr_i),
    .bus_rsp_i   (bus_rsp_i),
    .get_byte_i  (get_byte),
    .get_last_i  (get_last),
    .bus_req_o   (bus_req_o),
    .get_load_o  (get_load),
    .get_next_o  (get_next),
    .data_stb_o  (data_stb),
    .data_byte_o (data_byte),
    .bcast_stb_o (bcast_stb),
    .done_o      (done_o)
  );

  ccc_get_data u_get_data (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .cmd_i      (cmd),
    .csr_i      (csr_i),
    .get_load_i (get_load),
    .get_next_i (get_next),
    .get_byte_o (get_byte),
    .get_last_o (get_last)
  );

  ccc_set_actions u_set_actions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .sta_addr_i  (addr_i.sta),
    .data_stb_i  (data_stb),
    .data_byte_i (data_byte),
    .bcast_stb_i (bcast_stb),
    .events_o    (events_o)
  );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the CCC handler testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_ccc -f all.f -o sim_ccc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ccc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -qx "Simulation PASSED" sim.log; then
  exit 0
fi
exit 1

/* tb_ccc.sv */
// Testbench for the CCC handler with bus engine model, reference model, checker and scenarios
`timescale 1ns/1ps
`default_nettype none

module tb_ccc
  import ccc_pkg::*;
();

  logic         clk;
  logic         rst_n;
  ccc_code_t    ccc;
  logic         ccc_valid;
  logic         done;
  bus_rsp_t     bus_rsp;
  bus_req_t     bus_req;
  target_addr_t addr;
  csr_get_t     csr;
  ccc_events_t  events;

  // Scripted rx item, a byte or a bus condition
  typedef struct packed {
    logic       rstart;
    logic       stop;
    logic [7:0] data;
  } rx_item_t;

  typedef struct packed {
    logic       is_bit;
    logic [7:0] value;
  } tx_item_t;

  // Reply bytes left aligned, first byte on top
  typedef struct packed {
    logic [2:0]  len;
    logic [47:0] bytes;
    ccc_events_t ev;
  } expect_t;

  rx_item_t    rx_script[$];
  tx_item_t    tx_log[$];
  tx_item_t    exp_tx[$];
  ccc_events_t ev_log[$];

  integer seed         = 32'h1c57_e849;
  int     checks       = 0;
  int     errors       = 0;
  int     timeouts     = 0;
  int     cyc          = 0;
  int     done_cnt     = 0;
  int     done_cyc     = 0;
  int     stop_cyc     = 0;
  int     stop_at      = -1;
  int     tx_byte_cnt  = 0;
  int     busy_at_done = 0;
  int     underruns    = 0;

  ccc_top dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .ccc_i       (ccc),
    .ccc_valid_i (ccc_valid),
    .done_o      (done),
    .bus_rsp_i   (bus_rsp),
    .bus_req_o   (bus_req),
    .addr_i      (addr),
    .csr_i       (csr),
    .events_o    (events)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin : cycle_counter
    forever begin
      @(posedge clk);
      cyc = cyc + 1;
    end
  end

  // Bus engine, answers each request after 1 to 4 cycles
  initial begin : bus_engine
    bus_req_t req;
    rx_item_t item;
    tx_item_t tx;
    int       delay;
    bus_rsp = '0;
    forever begin
      @(negedge clk);
      req     = bus_req;
      bus_rsp = '0;
      if (rst_n && (req.rx_bit || req.rx_byte || req.tx_bit || req.tx_byte)) begin
        delay = 1 + ($random(seed) & 3);
        repeat (delay - 1) @(negedge clk);
        req = bus_req;
        if (req.rx_bit) begin
          bus_rsp.rx_done = 1'b1;
        end else if (req.rx_byte) begin
          if (rx_script.size() == 0) begin
            // Unstick the DUT with a STOP
            underruns        = underruns + 1;
            bus_rsp.stop_det = 1'b1;
          end else begin
            item = rx_script.pop_front();
            if (item.stop) begin
              bus_rsp.stop_det = 1'b1;
            end else if (item.rstart) begin
              bus_rsp.rstart_det = 1'b1;
            end else begin
              bus_rsp.rx_done = 1'b1;
              bus_rsp.rx_data = item.data;
            end
          end
        end else if (req.tx_byte) begin
          if (tx_byte_cnt == stop_at) begin
            bus_rsp.stop_det = 1'b1;
            stop_cyc         = cyc;
          end else begin
            tx.is_bit = 1'b0;
            tx.value  = req.tx_value;
            tx_log.push_back(tx);
            tx_byte_cnt     = tx_byte_cnt + 1;
            bus_rsp.tx_done = 1'b1;
          end
        end else if (req.tx_bit) begin
          tx.is_bit = 1'b1;
          tx.value  = {7'b0, req.tx_value[0]};
          tx_log.push_back(tx);
          bus_rsp.tx_done = 1'b1;
        end
      end
    end
  end

  // Event pulses and done strobes, sampled away from the clock edge
  initial begin : monitor
    forever begin
      @(negedge clk);
      if (rst_n) begin
        if (events != '0) begin
          ev_log.push_back(events);
        end
        if (done) begin
          done_cnt = done_cnt + 1;
          done_cyc = cyc;
          if (bus_req != '0) begin
            busy_at_done = busy_at_done + 1;
          end
        end
      end
    end
  end

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks = checks + 1;
    if (expected !== actual) begin
      errors = errors + 1;
      $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  // Expected reply bytes and events from the I3C CCC rules
  function automatic expect_t reference_model(input ccc_code_t code, input csr_get_t regs,
                                              input logic [7:0] data, input logic [6:0] sta);
    expect_t e;
    e = '0;
    case (code)
      CCC_DIRECT_GETBCR: begin
        e.len   = 3'd1;
        e.bytes = {regs.bcr, 40'h0};
      end
      CCC_DIRECT_GETDCR: begin
        e.len   = 3'd1;
        e.bytes = {regs.dcr, 40'h0};
      end
      CCC_DIRECT_GETSTATUS: begin
        e.len   = 3'd2;
        e.bytes = {regs.status, 32'h0};
      end
      CCC_DIRECT_GETMWL: begin
        e.len   = 3'd2;
        e.bytes = {regs.mwl, 32'h0};
      end
      // Read length then fixed IBI payload size
      CCC_DIRECT_GETMRL: begin
        e.len   = 3'd3;
        e.bytes = {regs.mrl, 8'hFF, 24'h0};
      end
      CCC_DIRECT_GETPID: begin
        e.len   = 3'd6;
        e.bytes = regs.pid;
      end
      CCC_DIRECT_ENEC: begin
        e.ev.enec_ibi = data[0];
        e.ev.enec_crr = data[1];
        e.ev.enec_hj  = data[3];
      end
      CCC_DIRECT_DISEC: begin
        e.ev.disec_ibi = data[0];
        e.ev.disec_crr = data[1];
        e.ev.disec_hj  = data[3];
      end
      CCC_DIRECT_SETDASA: begin
        e.ev.dasa_valid = 1'b1;
        e.ev.dasa       = data;
      end
      CCC_BCAST_SETAASA: begin
        e.ev.dasa_valid = 1'b1;
        e.ev.dasa       = {1'b0, sta};
      end
      CCC_BCAST_RSTDAA: e.ev.rstdaa = 1'b1;
      default: begin
      end
    endcase
    return e;
  endfunction

  task automatic push_rx(input logic rstart, input logic stop, input logic [7:0] data);
    rx_item_t item;
    item.rstart = rstart;
    item.stop   = stop;
    item.data   = data;
    rx_script.push_back(item);
  endtask

  // ACK, then byte and T-bit pairs
  task automatic expect_stream(input expect_t e);
    tx_item_t item;
    item.is_bit = 1'b1;
    item.value  = 8'h00;
    exp_tx.push_back(item);
    for (int k = 0; k < int'(e.len); k++) begin
      item.is_bit = 1'b0;
      item.value  = 8'(e.bytes >> (40 - 8 * k));
      exp_tx.push_back(item);
      item.is_bit = 1'b1;
      item.value  = (k < int'(e.len) - 1) ? 8'h01 : 8'h00;
      exp_tx.push_back(item);
    end
  endtask

  task automatic clear_run();
    rx_script.delete();
    tx_log.delete();
    exp_tx.delete();
    ev_log.delete();
    tx_byte_cnt  = 0;
    busy_at_done = 0;
    underruns    = 0;
  endtask

  task automatic randomize_csr();
    csr.bcr    = 8'($random(seed));
    csr.dcr    = 8'($random(seed));
    csr.status = 16'($random(seed));
    csr.mwl    = 16'($random(seed));
    csr.mrl    = 16'($random(seed));
    csr.pid    = {16'($random(seed)), 32'($random(seed))};
  endtask

  task automatic start_ccc(input ccc_code_t code);
    ccc       = code;
    ccc_valid = 1'b1;
    @(negedge clk);
    ccc_valid = 1'b0;
  endtask

  task automatic wait_done(input int start_cnt);
    int cycles;
    cycles = 0;
    while (done_cnt == start_cnt && cycles < 400) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    // Let late pulses reach the monitor
    repeat (2) @(negedge clk);
    if (done_cnt == start_cnt) begin
      timeouts = timeouts + 1;
      $display("Timeout: done_o did not pulse within 400 cycles at %0t", $time);
    end else begin
      check_value("done_o pulse count", 64'(start_cnt + 1), 64'(done_cnt));
    end
  endtask

  task automatic compare_result(input expect_t e);
    check_value("tx item count", 64'(exp_tx.size()), 64'(tx_log.size()));
    for (int i = 0; i < exp_tx.size() && i < tx_log.size(); i++) begin
      check_value($sformatf("bus_req_o.tx_value item %0d", i), 64'(exp_tx[i]), 64'(tx_log[i]));
    end
    check_value("events_o pulse count", (e.ev != '0) ? 64'h1 : 64'h0, 64'(ev_log.size()));
    if (ev_log.size() != 0) begin
      check_value("events_o", 64'(e.ev), 64'(ev_log[0]));
    end
    check_value("bus_req_o at done_o", 64'h0, 64'(busy_at_done));
    check_value("rx script underruns", 64'h0, 64'(underruns));
  endtask

  // Direct CCC with optional defining byte, one address phase, then STOP
  task automatic run_direct(input ccc_code_t code, input logic [6:0] target, input logic rnw,
                            input logic [7:0] data, input bit addressed, input bit with_def);
    expect_t e;
    int      start_cnt;
    clear_run();
    if (with_def) begin
      push_rx(1'b0, 1'b0, 8'($random(seed)));
    end
    push_rx(1'b1, 1'b0, 8'h00);
    push_rx(1'b0, 1'b0, {target, rnw});
    if (!rnw) begin
      push_rx(1'b0, 1'b0, data);
    end
    push_rx(1'b0, 1'b1, 8'h00);
    start_cnt = done_cnt;
    start_ccc(code);
    wait_done(start_cnt);
    e = reference_model(code, csr, data, addr.sta);
    if (!addressed) begin
      e = '0;
    end
    expect_stream(e);
    compare_result(e);
  endtask

  task automatic run_bcast(input ccc_code_t code);
    expect_t e;
    int      start_cnt;
    clear_run();
    start_cnt = done_cnt;
    start_ccc(code);
    wait_done(start_cnt);
    e = reference_model(code, csr, 8'h00, addr.sta);
    compare_result(e);
  endtask

  // GETPID cut short by a STOP in place of the third byte
  task automatic run_stop_get();
    expect_t e;
    int      start_cnt;
    clear_run();
    randomize_csr();
    push_rx(1'b1, 1'b0, 8'h00);
    push_rx(1'b0, 1'b0, {addr.dyn, 1'b1});
    stop_at   = 2;
    start_cnt = done_cnt;
    start_ccc(CCC_DIRECT_GETPID);
    wait_done(start_cnt);
    stop_at = -1;
    e = reference_model(CCC_DIRECT_GETPID, csr, 8'h00, addr.sta);
    expect_stream(e);
    while (exp_tx.size() > 5) begin
      void'(exp_tx.pop_back());
    end
    compare_result(e);
    check_value("done_o delay after stop_det", 64'h1, 64'(done_cyc - stop_cyc));
  endtask

  initial begin : stimulus
    ccc_code_t  get_codes [6];
    logic [7:0] data;
    get_codes = '{CCC_DIRECT_GETBCR, CCC_DIRECT_GETDCR, CCC_DIRECT_GETSTATUS,
                  CCC_DIRECT_GETMWL, CCC_DIRECT_GETMRL, CCC_DIRECT_GETPID};
    ccc       = '0;
    ccc_valid = 1'b0;
    addr      = '{sta: 7'h2A, sta_valid: 1'b1, dyn: 7'h35, dyn_valid: 1'b1};
    csr       = '0;
    rst_n     = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Quiet outputs with no command
    repeat (5) begin
      @(negedge clk);
      check_value("bus_req_o", 64'h0, 64'(bus_req));
      check_value("done_o", 64'h0, 64'(done));
      check_value("events_o", 64'h0, 64'(events));
    end
    for (int i = 0; i < 6; i++) begin
      randomize_csr();
      run_direct(get_codes[i], addr.dyn, 1'b1, 8'h00, 1'b1, (i % 2) == 1);
    end
    repeat (2) begin
      data = 8'($random(seed));
      run_direct(CCC_DIRECT_ENEC, addr.dyn, 1'b0, data, 1'b1, 1'b0);
      data = 8'($random(seed));
      run_direct(CCC_DIRECT_DISEC, addr.dyn, 1'b0, data, 1'b1, 1'b1);
      data = 8'($random(seed));
      run_direct(CCC_DIRECT_SETDASA, addr.dyn, 1'b0, data, 1'b1, 1'b0);
    end
    run_bcast(CCC_BCAST_RSTDAA);
    run_bcast(CCC_BCAST_SETAASA);
    // Other target on the bus
    randomize_csr();
    run_direct(CCC_DIRECT_GETBCR, 7'h12, 1'b1, 8'h00, 1'b0, 1'b0);
    run_direct(CCC_DIRECT_ENEC, 7'h12, 1'b0, 8'h0B, 1'b0, 1'b0);
    // Static address ignored while a dynamic one is valid
    run_direct(CCC_DIRECT_GETBCR, addr.sta, 1'b1, 8'h00, 1'b0, 1'b0);
    // Static address only while no dynamic one
    addr.dyn_valid = 1'b0;
    run_direct(CCC_DIRECT_GETDCR, addr.sta, 1'b1, 8'h00, 1'b1, 1'b0);
    run_direct(CCC_DIRECT_SETDASA, addr.sta, 1'b0, 8'h6C, 1'b1, 1'b0);
    addr.dyn_valid = 1'b1;
    run_stop_get();
    $display("CCC testbench done: %0d checks, %0d errors, %0d timeouts",
             checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
